/* include/sprite_cfg.svh */
`ifndef SPRITE_CFG_SVH
`define SPRITE_CFG_SVH

// Screen position and sprite coordinate width
`define SPRITE_POS_WIDTH 9

// Sprite table in sprite RAM
`define SPRITE_TABLE_AWIDTH 8
`define SPRITE_COUNT 64
`define SPRITE_ENTRY_BYTES 4

// Image ROM, offsets for each size sit in its first nine bytes
`define SPRITE_ROM_AWIDTH 17

// Hidden border on the left and top edges
`define SPRITE_BORDER 32

// Last hcnt at which rendering may still run on a line
`define SPRITE_FAILSAFE_HCNT 329

// One slot covers the whole 9-bit x range
`define SPRITE_LB_DEPTH 512

`endif

/* verilog/sprite_pkg.sv */
`default_nettype none

`include "sprite_cfg.svh"

package sprite_pkg;

	// Line-buffer and palette word
	// Bit 15 alpha, then blue, green, red at 5 bits each
	typedef logic [15:0] pixel_t;

	// Sprite size as held in table byte 0
	typedef enum logic [1:0] {
		SIZE_32 = 2'd0,
		SIZE_16 = 2'd1,
		SIZE_8  = 2'd2,
		SIZE_1  = 2'd3
	} size_code_e;

	// One sprite line to draw, handed from scanner to renderer
	typedef struct packed {
		logic [`SPRITE_POS_WIDTH-1:0] x;
		logic [4:0]                   row;
		logic [6:0]                   image;
		size_code_e                   size;
		logic                         mirror;
		logic [1:0]                   palette;
	} sprite_job_t;

endpackage

`default_nettype wire

/* verilog/sprite_offset_loader.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sprite_cfg.svh"

module sprite_offset_loader (
	input  wire                           clk,
	input  wire                           reset,
	input  wire [7:0]                     sprom_data,
	input  wire [`SPRITE_ROM_AWIDTH-1:0]  render_rom_addr,
	output logic [`SPRITE_ROM_AWIDTH-1:0] sprom_addr,
	output logic [`SPRITE_ROM_AWIDTH-1:0] offset_32,
	output logic [`SPRITE_ROM_AWIDTH-1:0] offset_16,
	output logic [`SPRITE_ROM_AWIDTH-1:0] offset_8,
	output logic                          offsets_ready
);

	// ROM header byte being fetched
	logic [3:0]  byte_idx;
	// Second cycle of a byte, ROM data is valid
	logic        data_phase;
	// Earlier bytes of the offset being assembled
	logic [15:0] shift_q;

	// Renderer gets the ROM once the header is read
	assign sprom_addr = offsets_ready ? render_rom_addr : `SPRITE_ROM_AWIDTH'(byte_idx);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			byte_idx      <= 4'd0;
			data_phase    <= 1'b0;
			offsets_ready <= 1'b0;
		end
		else if (!offsets_ready)
		begin
			data_phase <= ~data_phase;
			if (data_phase)
			begin
				byte_idx <= byte_idx + 4'd1;
				// Byte 8 is the low byte of the 8x8 offset
				if (byte_idx == 4'd8)
					offsets_ready <= 1'b1;
			end
		end
	end

	// Most significant byte first, three bytes per offset
	always_ff @(posedge clk)
	begin
		if (!offsets_ready && data_phase)
		begin
			shift_q <= {shift_q[7:0], sprom_data};
			case (byte_idx)
				4'd2: offset_32 <= `SPRITE_ROM_AWIDTH'({shift_q, sprom_data});
				4'd5: offset_16 <= `SPRITE_ROM_AWIDTH'({shift_q, sprom_data});
				4'd8: offset_8 <= `SPRITE_ROM_AWIDTH'({shift_q, sprom_data});
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/sprite_scanner.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sprite_cfg.svh"

module sprite_scanner import sprite_pkg::*; (
	input  wire                             clk,
	input  wire                             reset,
	input  wire                             hsync,
	input  wire [`SPRITE_POS_WIDTH-1:0]     hcnt,
	input  wire [`SPRITE_POS_WIDTH-1:0]     vcnt,
	input  wire                             offsets_ready,
	input  wire [7:0]                       spriteram_data,
	input  wire                             job_done,
	output logic [`SPRITE_TABLE_AWIDTH-1:0] spriteram_addr,
	output logic                            line_start,
	output logic                            job_start,
	output sprite_job_t                     job,
	output logic                            line_abort
);

	localparam int PW = `SPRITE_POS_WIDTH;
	localparam int IDX_W = $clog2(`SPRITE_COUNT);
	localparam logic [IDX_W-1:0] LAST_INDEX = IDX_W'(`SPRITE_COUNT - 1);
	localparam logic [PW-1:0] BORDER = PW'(`SPRITE_BORDER);

	typedef enum logic [2:0] {
		S_IDLE,
		S_ADDR,
		S_WAIT,
		S_READ,
		S_BUSY
	} state_e;

	state_e           state;
	logic             hsync_last;
	logic [IDX_W-1:0] index;
	logic [PW-1:0]    active_y;
	logic             y_hi;
	logic [PW-1:0]    spr_y;
	logic [PW:0]      spr_y_last;
	logic [4:0]       size_m1;
	logic             y_hit;
	logic             advance;

	assign line_start = hsync && !hsync_last && offsets_ready;

	// Low byte of y comes straight off the RAM in the byte 1 read
	assign spr_y = {y_hi, spriteram_data};

	always_comb
	begin
		case (job.size)
			SIZE_32: size_m1 = 5'd31;
			SIZE_16: size_m1 = 5'd15;
			SIZE_8:  size_m1 = 5'd7;
			default: size_m1 = 5'd0;
		endcase
	end

	// One bit wider so sprites near the bottom do not wrap
	assign spr_y_last = {1'b0, spr_y} + {{(PW-4){1'b0}}, size_m1};
	assign y_hit = (active_y >= spr_y) && ({1'b0, active_y} <= spr_y_last);

	// Entry finished: disabled, off this line, or rendered
	assign advance = (state == S_READ && spriteram_addr[1:0] == 2'd0 && !spriteram_data[7])
		|| (state == S_READ && spriteram_addr[1:0] == 2'd1 && !y_hit)
		|| (state == S_BUSY && job_done);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state          <= S_IDLE;
			hsync_last     <= 1'b0;
			spriteram_addr <= '0;
			job_start      <= 1'b0;
			line_abort     <= 1'b0;
		end
		else
		begin
			hsync_last <= hsync;
			job_start  <= 1'b0;
			line_abort <= 1'b0;

			case (state)
				S_IDLE:
				begin
					if (line_start)
					begin
						active_y <= (vcnt == PW'(255)) ? BORDER : vcnt + BORDER + PW'(1);
						index    <= '0;
						state    <= S_ADDR;
					end
				end
				S_ADDR:
				begin
					spriteram_addr <= `SPRITE_TABLE_AWIDTH'(index * `SPRITE_ENTRY_BYTES);
					state          <= S_WAIT;
				end
				S_WAIT:
					state <= S_READ;
				S_READ:
				begin
					spriteram_addr <= spriteram_addr + 1'b1;
					state          <= S_WAIT;
					case (spriteram_addr[1:0])
						2'd0:
						begin
							// Bit 6 is the collision flag, not used here
							job.palette <= spriteram_data[5:4];
							job.size    <= size_code_e'(spriteram_data[3:2]);
							job.mirror  <= spriteram_data[1];
							y_hi        <= spriteram_data[0];
						end
						2'd1:
							job.row <= 5'(active_y - spr_y);
						2'd2:
						begin
							job.image   <= spriteram_data[7:1];
							job.x[PW-1] <= spriteram_data[0];
						end
						default:
						begin
							job.x[7:0] <= spriteram_data;
							job_start  <= 1'b1;
							state      <= S_BUSY;
						end
					endcase
				end
				default: ;
			endcase

			if (advance)
			begin
				if (index == LAST_INDEX)
					state <= S_IDLE;
				else
				begin
					index <= index + 1'b1;
					state <= S_ADDR;
				end
			end

			// Out of time for this line, give up so the next one starts clean
			if (state != S_IDLE && hcnt == PW'(`SPRITE_FAILSAFE_HCNT))
			begin
				state      <= S_IDLE;
				job_start  <= 1'b0;
				line_abort <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/sprite_pixel_renderer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sprite_cfg.svh"

module sprite_pixel_renderer import sprite_pkg::*; (
	input  wire                           clk,
	input  wire                           reset,
	input  wire                           job_start,
	input  wire sprite_job_t              job,
	input  wire                           line_abort,
	input  wire [`SPRITE_ROM_AWIDTH-1:0]  offset_32,
	input  wire [`SPRITE_ROM_AWIDTH-1:0]  offset_16,
	input  wire [`SPRITE_ROM_AWIDTH-1:0]  offset_8,
	input  wire [7:0]                     sprom_data,
	input  wire pixel_t                   palrom_data,
	output logic [`SPRITE_ROM_AWIDTH-1:0] render_rom_addr,
	output logic [7:0]                    palrom_addr,
	output logic                          lb_wr,
	output logic [`SPRITE_POS_WIDTH-1:0]  lb_wr_addr,
	output pixel_t                        lb_wr_data,
	output logic                          job_done
);

	localparam int RW = `SPRITE_ROM_AWIDTH;
	localparam int PW = `SPRITE_POS_WIDTH;

	// Pipeline stages: ROM address, ROM data, palette address, palette data
	logic [3:0]    vld;
	logic [3:0]    last;
	logic [4:0]    pix;
	logic [4:0]    size_m1;
	logic          mirror_q;
	logic [1:0]    pal_q;
	logic [PW-1:0] pos;
	logic [4:0]    job_size_m1;
	logic [RW-1:0] start_addr;

	// Start of this row in the image ROM
	always_comb
	begin
		case (job.size)
			SIZE_32:
			begin
				job_size_m1 = 5'd31;
				start_addr  = offset_32 + RW'({job.image, 10'b0}) + RW'({job.row, 5'b0});
			end
			SIZE_16:
			begin
				job_size_m1 = 5'd15;
				start_addr  = offset_16 + RW'({job.image, 8'b0}) + RW'({job.row[3:0], 4'b0});
			end
			SIZE_8:
			begin
				job_size_m1 = 5'd7;
				start_addr  = offset_8 + RW'({job.image, 6'b0}) + RW'({job.row[2:0], 3'b0});
			end
			default:
			begin
				job_size_m1 = 5'd0;
				start_addr  = offset_8 + RW'(job.image);
			end
		endcase
		// Mirrored rows are walked backwards from one size further on
		if (job.mirror)
			start_addr = start_addr + RW'(job_size_m1) + RW'(1);
	end

	always_ff @(posedge clk)
	begin
		if (reset || line_abort)
		begin
			vld      <= 4'b0;
			lb_wr    <= 1'b0;
			job_done <= 1'b0;
		end
		else
		begin
			vld[3:1] <= vld[2:0];
			// Only opaque palette entries reach the line
			lb_wr    <= vld[3] && palrom_data[15];
			job_done <= vld[3] && last[3];
			if (job_start)
				vld[0] <= 1'b1;
			else if (vld[0] && last[0])
				vld[0] <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		last[3:1] <= last[2:0];

		if (job_start)
		begin
			render_rom_addr <= start_addr;
			size_m1         <= job_size_m1;
			mirror_q        <= job.mirror;
			pal_q           <= job.palette;
			pos             <= job.x;
			pix             <= 5'd0;
			last[0]         <= (job_size_m1 == 5'd0);
		end
		else if (vld[0] && !last[0])
		begin
			render_rom_addr <= mirror_q ? render_rom_addr - 1'b1 : render_rom_addr + 1'b1;
			pix             <= pix + 5'd1;
			last[0]         <= (pix + 5'd1 == size_m1);
		end

		if (vld[1])
			palrom_addr <= {pal_q, sprom_data[4:0], 1'b0};

		if (vld[3])
		begin
			lb_wr_addr <= pos;
			lb_wr_data <= palrom_data;
			pos        <= pos + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* verilog/sprite_line_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sprite_cfg.svh"

module sprite_line_buffer import sprite_pkg::*; (
	input  wire                          clk,
	input  wire                          reset,
	input  wire                          line_start,
	input  wire [`SPRITE_POS_WIDTH-1:0]  hcnt,
	input  wire                          lb_wr,
	input  wire [`SPRITE_POS_WIDTH-1:0]  lb_wr_addr,
	input  wire pixel_t                  lb_wr_data,
	output logic [7:0]                   spr_r,
	output logic [7:0]                   spr_g,
	output logic [7:0]                   spr_b,
	output logic                         spr_a
);

	localparam int PW = `SPRITE_POS_WIDTH;

	// Slot being scanned out, the other one takes renderer writes
	logic          slot;
	logic          rd_slot;
	logic [PW-1:0] rd_addr;
	// Entry read last cycle, cleared now
	logic          clr_slot;
	logic [PW-1:0] clr_addr;
	pixel_t        rd_data;

	// The first read of a new line already comes from the fresh slot
	assign rd_slot = slot ^ line_start;
	assign rd_addr = hcnt + PW'(`SPRITE_BORDER);

	for (genvar s = 0; s < 2; s++)
	begin : g_slot
		pixel_t mem [`SPRITE_LB_DEPTH];
		pixel_t q;

		initial
		begin
			for (int i = 0; i < `SPRITE_LB_DEPTH; i++)
				mem[i] = '0;
		end

		always_ff @(posedge clk)
		begin
			q <= mem[rd_addr];
			if (lb_wr && slot != 1'(s))
				mem[lb_wr_addr] <= lb_wr_data;
			else if (clr_slot == 1'(s))
				mem[clr_addr] <= '0;
		end
	end

	assign rd_data = clr_slot ? g_slot[1].q : g_slot[0].q;

	always_ff @(posedge clk)
	begin
		clr_slot <= rd_slot;
		clr_addr <= rd_addr;
		// 5 to 8 bits by repeating the top bits of each channel
		spr_r    <= {rd_data[4:0], rd_data[4:2]};
		spr_g    <= {rd_data[9:5], rd_data[9:7]};
		spr_b    <= {rd_data[14:10], rd_data[14:12]};
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			slot  <= 1'b0;
			spr_a <= 1'b0;
		end
		else
		begin
			slot  <= rd_slot;
			spr_a <= rd_data[15];
		end
	end

endmodule

`default_nettype wire

/* verilog/sprite_engine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sprite_cfg.svh"

module sprite_engine import sprite_pkg::*; (
	input  wire                            clk,
	input  wire                            reset,
	input  wire                            hsync,
	input  wire [`SPRITE_POS_WIDTH-1:0]    hcnt,
	input  wire [`SPRITE_POS_WIDTH-1:0]    vcnt,
	output logic [`SPRITE_TABLE_AWIDTH-1:0] spriteram_addr,
	input  wire [7:0]                      spriteram_data,
	output logic [`SPRITE_ROM_AWIDTH-1:0]  sprom_addr,
	input  wire [7:0]                      sprom_data,
	output logic [7:0]                     palrom_addr,
	input  wire pixel_t                    palrom_data,
	output logic [7:0]                     spr_r,
	output logic [7:0]                     spr_g,
	output logic [7:0]                     spr_b,
	output logic                           spr_a
);

	logic [`SPRITE_ROM_AWIDTH-1:0] render_rom_addr;
	logic [`SPRITE_ROM_AWIDTH-1:0] offset_32;
	logic [`SPRITE_ROM_AWIDTH-1:0] offset_16;
	logic [`SPRITE_ROM_AWIDTH-1:0] offset_8;
	logic                          offsets_ready;

	logic                          line_start;
	logic                          job_start;
	sprite_job_t                   job;
	logic                          line_abort;
	logic                          job_done;

	logic                          lb_wr;
	logic [`SPRITE_POS_WIDTH-1:0]  lb_wr_addr;
	pixel_t                        lb_wr_data;

	// Owns the sprite ROM until the size offsets are in
	sprite_offset_loader u_loader (
		.clk             (clk),
		.reset           (reset),
		.sprom_data      (sprom_data),
		.render_rom_addr (render_rom_addr),
		.sprom_addr      (sprom_addr),
		.offset_32       (offset_32),
		.offset_16       (offset_16),
		.offset_8        (offset_8),
		.offsets_ready   (offsets_ready)
	);

	sprite_scanner u_scanner (
		.clk            (clk),
		.reset          (reset),
		.hsync          (hsync),
		.hcnt           (hcnt),
		.vcnt           (vcnt),
		.offsets_ready  (offsets_ready),
		.spriteram_data (spriteram_data),
		.job_done       (job_done),
		.spriteram_addr (spriteram_addr),
		.line_start     (line_start),
		.job_start      (job_start),
		.job            (job),
		.line_abort     (line_abort)
	);

	sprite_pixel_renderer u_renderer (
		.clk             (clk),
		.reset           (reset),
		.job_start       (job_start),
		.job             (job),
		.line_abort      (line_abort),
		.offset_32       (offset_32),
		.offset_16       (offset_16),
		.offset_8        (offset_8),
		.sprom_data      (sprom_data),
		.palrom_data     (palrom_data),
		.render_rom_addr (render_rom_addr),
		.palrom_addr     (palrom_addr),
		.lb_wr           (lb_wr),
		.lb_wr_addr      (lb_wr_addr),
		.lb_wr_data      (lb_wr_data),
		.job_done        (job_done)
	);

	sprite_line_buffer u_line_buffer (
		.clk        (clk),
		.reset      (reset),
		.line_start (line_start),
		.hcnt       (hcnt),
		.lb_wr      (lb_wr),
		.lb_wr_addr (lb_wr_addr),
		.lb_wr_data (lb_wr_data),
		.spr_r      (spr_r),
		.spr_g      (spr_g),
		.spr_b      (spr_b),
		.spr_a      (spr_a)
	);

endmodule

`default_nettype wire

/* dv/sprite_mem_models.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sprite_cfg.svh"

module sprite_mem_models import sprite_pkg::*; (
	input  wire                            clk,
	input  wire [`SPRITE_TABLE_AWIDTH-1:0] spriteram_addr,
	output logic [7:0]                     spriteram_data,
	input  wire [`SPRITE_ROM_AWIDTH-1:0]   sprom_addr,
	output logic [7:0]                     sprom_data,
	input  wire [7:0]                      palrom_addr,
	output pixel_t                         palrom_data
);

	logic [7:0] spriteram [1 << `SPRITE_TABLE_AWIDTH];
	logic [7:0] sprom [1 << `SPRITE_ROM_AWIDTH];
	pixel_t     palrom [256];

	initial
	begin
		spriteram_data = '0;
		sprom_data     = '0;
		palrom_data    = '0;
	end

	// Data shows up one clock after the address
	always @(posedge clk)
	begin
		spriteram_data <= spriteram[spriteram_addr];
		sprom_data     <= sprom[sprom_addr];
		palrom_data    <= palrom[palrom_addr];
	end

	task automatic write_table(input logic [`SPRITE_TABLE_AWIDTH-1:0] addr,
		input logic [7:0] data);
		spriteram[addr] = data;
	endtask

	task automatic write_rom(input logic [`SPRITE_ROM_AWIDTH-1:0] addr, input logic [7:0] data);
		sprom[addr] = data;
	endtask

	task automatic write_palette(input logic [7:0] addr, input pixel_t data);
		palrom[addr] = data;
	endtask

endmodule

`default_nettype wire

/* dv/sprite_engine_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sprite_cfg.svh"

module sprite_engine_tb import sprite_pkg::*; ();

	localparam logic [16:0] OFF_32 = 17'h01000;
	localparam logic [16:0] OFF_16 = 17'h0B000;
	localparam logic [16:0] OFF_8 = 17'h13000;
	localparam int LINE_LEN = 400;
	localparam int ROM_SIZE = 1 << `SPRITE_ROM_AWIDTH;

	logic                            clk;
	logic                            reset;
	logic                            hsync;
	logic [`SPRITE_POS_WIDTH-1:0]    hcnt;
	logic [`SPRITE_POS_WIDTH-1:0]    vcnt;
	logic [`SPRITE_TABLE_AWIDTH-1:0] spriteram_addr;
	logic [7:0]                      spriteram_data;
	logic [`SPRITE_ROM_AWIDTH-1:0]   sprom_addr;
	logic [7:0]                      sprom_data;
	logic [7:0]                      palrom_addr;
	pixel_t                          palrom_data;
	logic [7:0]                      spr_r;
	logic [7:0]                      spr_g;
	logic [7:0]                      spr_b;
	logic                            spr_a;

	integer seed;
	int     errors;
	int     checks;
	int     line_no;
	// Line on screen now and the one being rendered for the next line
	pixel_t exp_cur [`SPRITE_LB_DEPTH];
	pixel_t exp_next [`SPRITE_LB_DEPTH];

	sprite_engine uut (
		.clk            (clk),
		.reset          (reset),
		.hsync          (hsync),
		.hcnt           (hcnt),
		.vcnt           (vcnt),
		.spriteram_addr (spriteram_addr),
		.spriteram_data (spriteram_data),
		.sprom_addr     (sprom_addr),
		.sprom_data     (sprom_data),
		.palrom_addr    (palrom_addr),
		.palrom_data    (palrom_data),
		.spr_r          (spr_r),
		.spr_g          (spr_g),
		.spr_b          (spr_b),
		.spr_a          (spr_a)
	);

	sprite_mem_models mem (
		.clk            (clk),
		.spriteram_addr (spriteram_addr),
		.spriteram_data (spriteram_data),
		.sprom_addr     (sprom_addr),
		.sprom_data     (sprom_data),
		.palrom_addr    (palrom_addr),
		.palrom_data    (palrom_data)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	function automatic int size_pixels(input logic [1:0] code);
		case (code)
			2'd0: return 32;
			2'd1: return 16;
			2'd2: return 8;
			default: return 1;
		endcase
	endfunction

	function automatic int size_offset(input logic [1:0] code);
		case (code)
			2'd0: return OFF_32;
			2'd1: return OFF_16;
			default: return OFF_8;
		endcase
	endfunction

	task automatic fill_memories();
		int   a;
		int   w;
		logic [71:0] header;
		// Every address bit reaches the five bits that pick the palette entry
		for (a = 0; a < ROM_SIZE; a++)
			mem.write_rom(17'(a), 8'((a * 29) ^ (a >> 5) ^ (a >> 10) ^ (a >> 15)));
		// Three 24-bit offsets with the high byte first
		header = {7'b0, OFF_32, 7'b0, OFF_16, 7'b0, OFF_8};
		for (a = 0; a < 9; a++)
			mem.write_rom(17'(a), header[71 - 8 * a -: 8]);
		// Palette 0 is fully opaque while the others have holes
		for (a = 0; a < 256; a++)
		begin
			w = $random(seed);
			mem.write_palette(8'(a), {(a < 64) | w[16], w[14:0]});
		end
	endtask

	task automatic set_sprite(input int idx, input logic en, input logic [1:0] pal,
		input logic [1:0] code, input logic mirror, input logic [8:0] y,
		input logic [6:0] img, input logic [8:0] x);
		mem.write_table(8'(4 * idx), {en, 1'b0, pal, code, mirror, y[8]});
		mem.write_table(8'(4 * idx + 1), y[7:0]);
		mem.write_table(8'(4 * idx + 2), {img, x[8]});
		mem.write_table(8'(4 * idx + 3), x[7:0]);
	endtask

	// Disabled entries still carry junk in their other bytes
	task automatic clear_table();
		int i;
		int r;
		for (i = 0; i < `SPRITE_COUNT; i++)
		begin
			r = $random(seed);
			mem.write_table(8'(4 * i), r[7:0] & 8'h7f);
			mem.write_table(8'(4 * i + 1), r[15:8]);
			mem.write_table(8'(4 * i + 2), r[23:16]);
			mem.write_table(8'(4 * i + 3), r[31:24]);
		end
	endtask

	task automatic random_sprite();
		int r;
		r = $random(seed);
		set_sprite(r & 63, 1'b1, r[7:6], r[9:8], r[10], 9'(line_no + 33 - r[31:27]),
			r[17:11], r[26:18]);
	endtask

	// Reference line for the next scanline drawn from the table as it is now
	task automatic build_expected(input int v);
		int     active;
		int     i;
		int     k;
		int     y;
		int     sz;
		int     base;
		int     addr;
		logic [7:0] b0;
		logic [7:0] b1;
		logic [7:0] b2;
		logic [7:0] b3;
		logic [7:0] d;
		pixel_t p;
		for (i = 0; i < `SPRITE_LB_DEPTH; i++)
			exp_next[i] = '0;
		active = (v == 255) ? `SPRITE_BORDER : v + `SPRITE_BORDER + 1;
		for (i = 0; i < `SPRITE_COUNT; i++)
		begin
			b0 = mem.spriteram[4 * i];
			b1 = mem.spriteram[4 * i + 1];
			b2 = mem.spriteram[4 * i + 2];
			b3 = mem.spriteram[4 * i + 3];
			y = {b0[0], b1};
			sz = size_pixels(b0[3:2]);
			if (b0[7] && active >= y && active <= y + sz - 1)
			begin
				base = size_offset(b0[3:2]) + b2[7:1] * sz * sz + (active - y) * sz;
				for (k = 0; k < sz; k++)
				begin
					addr = b0[1] ? base + sz - k : base + k;
					d = mem.sprom[addr % ROM_SIZE];
					p = mem.palrom[{b0[5:4], d[4:0], 1'b0}];
					// Later entries paint over earlier ones
					if (p[15])
						exp_next[({b2[0], b3} + k) % `SPRITE_LB_DEPTH] = p;
				end
			end
		end
	endtask

	task automatic report_mismatch(input string name, input logic [7:0] expected,
		input logic [7:0] actual, input int hp);
		errors++;
		$display("mismatch at %0t: %s expected %h actual %h (line %0d, hcnt %0d)",
			$time, name, expected, actual, line_no, hp);
	endtask

	task automatic check_pixel(input int hp);
		pixel_t     e;
		logic [7:0] er;
		logic [7:0] eg;
		logic [7:0] eb;
		e = exp_cur[hp + `SPRITE_BORDER];
		er = {e[4:0], e[4:2]};
		eg = {e[9:5], e[9:7]};
		eb = {e[14:10], e[14:12]};
		checks++;
		assert (spr_a === e[15]) else report_mismatch("spr_a", 8'(e[15]), 8'(spr_a), hp);
		assert (spr_r === er) else report_mismatch("spr_r", er, spr_r, hp);
		assert (spr_g === eg) else report_mismatch("spr_g", eg, spr_g, hp);
		assert (spr_b === eb) else report_mismatch("spr_b", eb, spr_b, hp);
	endtask

	// One full scanline with the output two clocks behind the presented hcnt
	task automatic run_line();
		int h;
		for (h = 0; h < `SPRITE_LB_DEPTH; h++)
			exp_cur[h] = exp_next[h];
		build_expected(line_no);
		for (h = 0; h < LINE_LEN; h++)
		begin
			@(posedge clk);
			#1;
			hcnt = 9'(h);
			vcnt = 9'(line_no);
			hsync = (h == 0);
			if (h >= 2)
				check_pixel(h - 2);
			assert (!uut.line_abort)
			else
			begin
				errors++;
				$display("rendering was cut off by the failsafe at hcnt %0d", h);
			end
		end
		line_no++;
	endtask

	task automatic run_scenarios();
		int i;
		int y;
		// Empty table
		repeat (3) run_line();
		// One opaque 8x8 sprite passing through its rows
		y = line_no + 33 + 3;
		set_sprite(10, 1'b1, 2'd0, 2'd2, 1'b0, 9'(y), 7'd5, 9'd100);
		repeat (14) run_line();
		// Holes in palette 1 and overlap order
		clear_table();
		y = line_no + 33 + 1;
		set_sprite(3, 1'b1, 2'd0, 2'd2, 1'b0, 9'(y), 7'd9, 9'd154);
		set_sprite(20, 1'b1, 2'd1, 2'd1, 1'b0, 9'(y), 7'd17, 9'd150);
		set_sprite(21, 1'b1, 2'd0, 2'd1, 1'b0, 9'(y + 4), 7'd33, 9'd160);
		repeat (6) run_line();
		// Every size with some of them mirrored
		clear_table();
		y = line_no + 33;
		set_sprite(30, 1'b1, 2'd2, 2'd0, 1'b0, 9'(y - 2), 7'd100, 9'd40);
		set_sprite(31, 1'b1, 2'd0, 2'd1, 1'b1, 9'(y), 7'd60, 9'd250);
		set_sprite(32, 1'b1, 2'd3, 2'd2, 1'b1, 9'(y + 1), 7'd77, 9'd380);
		set_sprite(33, 1'b1, 2'd0, 2'd3, 1'b0, 9'(y + 3), 7'd120, 9'd300);
		repeat (6) run_line();
		// Sprites turned off mid-frame must not linger
		set_sprite(30, 1'b0, 2'd2, 2'd0, 1'b0, 9'(y - 2), 7'd100, 9'd40);
		set_sprite(31, 1'b0, 2'd0, 2'd1, 1'b1, 9'(y), 7'd60, 9'd250);
		repeat (3) run_line();
		for (i = 0; i < 8; i++)
		begin
			clear_table();
			random_sprite();
			random_sprite();
			repeat (2) run_line();
		end
		clear_table();
		repeat (2) run_line();
	endtask

	initial
	begin
		int wait_cnt;
		int i;
		seed = 88750;
		errors = 0;
		checks = 0;
		line_no = 0;
		reset = 1'b1;
		hsync = 1'b0;
		hcnt = '0;
		vcnt = '0;
		for (i = 0; i < `SPRITE_LB_DEPTH; i++)
		begin
			exp_cur[i] = '0;
			exp_next[i] = '0;
		end
		fill_memories();
		clear_table();
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;

		// Lines only start once the offsets are in
		wait_cnt = 0;
		while (!uut.offsets_ready && wait_cnt < 64)
		begin
			@(posedge clk);
			#1;
			wait_cnt++;
		end
		if (!uut.offsets_ready)
		begin
			errors++;
			$display("timeout: offset loader not done after %0d cycles", wait_cnt);
		end
		else
			run_scenarios();

		$display("pixel checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* sprite_engine.f */
+incdir+include
verilog/sprite_pkg.sv
verilog/sprite_offset_loader.sv
verilog/sprite_scanner.sv
verilog/sprite_pixel_renderer.sv
verilog/sprite_line_buffer.sv
verilog/sprite_engine.sv
dv/sprite_mem_models.sv
dv/sprite_engine_tb.sv

/* Bender.yml */
package:
  name: sprite_engine

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/sprite_pkg.sv
      - verilog/sprite_offset_loader.sv
      - verilog/sprite_scanner.sv
      - verilog/sprite_pixel_renderer.sv
      - verilog/sprite_line_buffer.sv
      - verilog/sprite_engine.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/sprite_mem_models.sv
      - dv/sprite_engine_tb.sv
